// ==== common/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Cache geometry

// Byte address width of the load/store unit
`define DCACHE_ADDR_W 32

// Data word width
`define DCACHE_WORD_W 32

// Words in one cache line, also the memory port width in words
`define DCACHE_LINE_WORDS 4

// Number of lines, direct mapped
`define DCACHE_LINES 16

`endif

// ==== common/dcache_pkg.sv ====
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

  // Field widths derived from the geometry
  localparam int ADDR_W     = `DCACHE_ADDR_W;
  localparam int WORD_W     = `DCACHE_WORD_W;
  localparam int LINE_W     = `DCACHE_WORD_W * `DCACHE_LINE_WORDS;
  localparam int BYTE_OFF_W = $clog2(`DCACHE_WORD_W / 8);
  localparam int WORD_OFF_W = $clog2(`DCACHE_LINE_WORDS);
  localparam int LINE_OFF_W = WORD_OFF_W + BYTE_OFF_W;
  localparam int INDEX_W    = $clog2(`DCACHE_LINES);
  localparam int TAG_W      = ADDR_W - INDEX_W - LINE_OFF_W;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [INDEX_W-1:0]    index_t;
  typedef logic [TAG_W-1:0]      tag_t;
  typedef logic [WORD_W/8-1:0]   be_t;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    ALLOCATE,
    FLUSH_CHECK,
    FLUSH_WB,
    FLUSH_DONE
  } dcache_state_e;

endpackage

`default_nettype wire

// ==== common/dcache_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dcache_ctrl_if;

  // Controller to datapath
  logic cache_wr;
  logic line_wr;
  logic writeback_req;
  logic flush_active;
  logic flush_next;

  // Datapath to controller
  logic hit;
  logic dirty;
  logic flush_done;

  modport controller (
    output cache_wr, line_wr, writeback_req, flush_active, flush_next,
    input  hit, dirty, flush_done
  );

  modport datapath (
    input  cache_wr, line_wr, writeback_req, flush_active, flush_next,
    output hit, dirty, flush_done
  );

endinterface

`default_nettype wire

// ==== dcache/wb_dcache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_dcache_controller (
  input  wire logic          clk_i,
  input  wire logic          arst_n_i,

  dcache_ctrl_if.controller  ctrl,

  // Load/store unit and flush
  input  wire logic          dmem_sel_i,
  input  wire logic          dcache_flush_i,
  input  wire logic          lsu_req_i,
  input  wire logic          lsu_wr_i,
  output logic               lsu_ack_o,
  output logic               dcache_flush_ack_o,

  // Line-wide memory port
  output logic               mem_req_o,
  output logic               mem_wr_o,
  input  wire logic          mem_ack_i
);

  import dcache_pkg::*;

  dcache_state_e state_q;
  dcache_state_e state_d;

  // High in states that own the memory port
  logic          mem_cycle;
  // Forces one idle cycle on the port after every ack
  logic          mem_ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      mem_ack_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      mem_ack_q <= mem_ack_i;
    end
  end

  always_comb begin
    state_d             = state_q;
    ctrl.cache_wr       = 1'b0;
    ctrl.line_wr        = 1'b0;
    ctrl.writeback_req  = 1'b0;
    ctrl.flush_active   = 1'b0;
    ctrl.flush_next     = 1'b0;
    lsu_ack_o           = 1'b0;
    dcache_flush_ack_o  = 1'b0;
    mem_wr_o            = 1'b0;
    mem_cycle           = 1'b0;

    unique case (state_q)
      IDLE: begin
        // A flush pulse is lost if not taken here, so it wins
        if (dcache_flush_i) begin
          state_d = FLUSH_CHECK;
        end else if (lsu_req_i && dmem_sel_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (!dmem_sel_i) begin
          state_d = IDLE;
        end else if (ctrl.hit) begin
          lsu_ack_o     = 1'b1;
          ctrl.cache_wr = lsu_wr_i;
          state_d       = IDLE;
        end else if (ctrl.dirty) begin
          state_d = WRITEBACK;
        end else begin
          state_d = REFILL;
        end
      end
      WRITEBACK: begin
        ctrl.writeback_req = 1'b1;
        mem_wr_o           = 1'b1;
        mem_cycle          = 1'b1;
        if (mem_ack_i) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        mem_cycle = 1'b1;
        if (mem_ack_i) begin
          state_d = ALLOCATE;
        end
      end
      ALLOCATE: begin
        // Fill data was captured on the ack edge
        ctrl.line_wr = 1'b1;
        state_d      = LOOKUP;
      end
      FLUSH_CHECK: begin
        ctrl.flush_active = 1'b1;
        if (ctrl.dirty) begin
          state_d = FLUSH_WB;
        end else begin
          ctrl.flush_next = 1'b1;
          state_d         = ctrl.flush_done ? FLUSH_DONE : FLUSH_CHECK;
        end
      end
      FLUSH_WB: begin
        ctrl.flush_active  = 1'b1;
        ctrl.writeback_req = 1'b1;
        mem_wr_o           = 1'b1;
        mem_cycle          = 1'b1;
        if (mem_ack_i) begin
          ctrl.flush_next = 1'b1;
          state_d         = ctrl.flush_done ? FLUSH_DONE : FLUSH_CHECK;
        end
      end
      FLUSH_DONE: begin
        dcache_flush_ack_o = 1'b1;
        state_d            = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign mem_req_o = mem_cycle && !mem_ack_q;

  // Memory request holds until the memory answers
  a_mem_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_req_o && !mem_ack_i |=> mem_req_o);

  // An ack only answers a pending request
  a_ack_has_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(lsu_ack_o) |-> lsu_req_i);

endmodule

`default_nettype wire

// ==== dcache/wb_dcache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module wb_dcache_datapath (
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,

  dcache_ctrl_if.datapath         ctrl,

  // Load/store unit side
  input  wire dcache_pkg::addr_t  lsu_addr_i,
  input  wire dcache_pkg::word_t  lsu_wdata_i,
  input  wire dcache_pkg::be_t    lsu_sel_byte_i,
  output dcache_pkg::word_t       lsu_rdata_o,

  // Memory side
  input  wire dcache_pkg::line_t  mem_rdata_i,
  output dcache_pkg::line_t       mem_wdata_o,
  output dcache_pkg::addr_t       mem_addr_o
);

  import dcache_pkg::*;

  // Arrays
  tag_t                     tag_mem  [`DCACHE_LINES];
  line_t                    data_mem [`DCACHE_LINES];
  logic [`DCACHE_LINES-1:0] valid_q;
  logic [`DCACHE_LINES-1:0] dirty_q;

  index_t                   flush_cnt_q;
  line_t                    fill_q;

  // Request address fields
  tag_t                     req_tag;
  index_t                   req_idx;
  logic [WORD_OFF_W-1:0]    req_off;

  index_t                   sel_idx;
  line_t                    req_line;
  word_t                    old_word;
  word_t                    merged_word;

  assign {req_tag, req_idx, req_off} = lsu_addr_i[ADDR_W-1:BYTE_OFF_W];

  // Flush walks the lines by counter, everything else by request
  assign sel_idx = ctrl.flush_active ? flush_cnt_q : req_idx;

  assign req_line    = data_mem[req_idx];
  assign old_word    = req_line[req_off*WORD_W +: WORD_W];
  assign lsu_rdata_o = old_word;

  // Byte merge for stores
  always_comb begin
    for (int b = 0; b < WORD_W/8; b++) begin
      merged_word[b*8 +: 8] = lsu_sel_byte_i[b] ? lsu_wdata_i[b*8 +: 8]
                                                : old_word[b*8 +: 8];
    end
  end

  assign ctrl.hit        = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
  assign ctrl.dirty      = valid_q[sel_idx] && dirty_q[sel_idx];
  assign ctrl.flush_done = (flush_cnt_q == index_t'(`DCACHE_LINES - 1));

  // Victim address is rebuilt from the stored tag
  assign mem_addr_o  = ctrl.writeback_req ? {tag_mem[sel_idx], sel_idx, {LINE_OFF_W{1'b0}}}
                                          : {req_tag, req_idx, {LINE_OFF_W{1'b0}}};
  assign mem_wdata_o = data_mem[sel_idx];

  // Line state and flush counter
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q     <= '0;
      dirty_q     <= '0;
      flush_cnt_q <= '0;
    end else begin
      if (ctrl.line_wr) begin
        valid_q[req_idx] <= 1'b1;
        dirty_q[req_idx] <= 1'b0;
      end
      if (ctrl.cache_wr) begin
        dirty_q[req_idx] <= 1'b1;
      end
      if (ctrl.flush_next) begin
        dirty_q[flush_cnt_q] <= 1'b0;
        // Wraps to zero after the last line
        flush_cnt_q          <= flush_cnt_q + 1'b1;
      end
    end
  end

  // Tag and data storage
  always_ff @(posedge clk_i) begin
    fill_q <= mem_rdata_i;
    if (ctrl.line_wr) begin
      data_mem[req_idx] <= fill_q;
      tag_mem[req_idx]  <= req_tag;
    end
    if (ctrl.cache_wr) begin
      data_mem[req_idx][req_off*WORD_W +: WORD_W] <= merged_word;
    end
  end

  // Store hit and line fill come from different states
  a_no_dual_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ctrl.cache_wr && ctrl.line_wr));

endmodule

`default_nettype wire

// ==== hdl/wb_dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_dcache_top (
  input  wire logic               clk_i,
  input  wire logic               arst_n_i,
  input  wire logic               dmem_sel_i,
  input  wire logic               dcache_flush_i,

  // Load/store unit
  input  wire logic               lsu_req_i,
  input  wire logic               lsu_wr_i,
  input  wire dcache_pkg::addr_t  lsu_addr_i,
  input  wire dcache_pkg::word_t  lsu_wdata_i,
  input  wire dcache_pkg::be_t    lsu_sel_byte_i,
  output logic                    lsu_ack_o,
  output dcache_pkg::word_t       lsu_rdata_o,
  output logic                    dcache_flush_ack_o,

  // Data memory
  output logic                    mem_req_o,
  output logic                    mem_wr_o,
  output dcache_pkg::addr_t       mem_addr_o,
  output dcache_pkg::line_t       mem_wdata_o,
  input  wire dcache_pkg::line_t  mem_rdata_i,
  input  wire logic               mem_ack_i
);

  dcache_ctrl_if ctrl_if ();

  wb_dcache_controller u_controller (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .ctrl               (ctrl_if),
    .dmem_sel_i         (dmem_sel_i),
    .dcache_flush_i     (dcache_flush_i),
    .lsu_req_i          (lsu_req_i),
    .lsu_wr_i           (lsu_wr_i),
    .lsu_ack_o          (lsu_ack_o),
    .dcache_flush_ack_o (dcache_flush_ack_o),
    .mem_req_o          (mem_req_o),
    .mem_wr_o           (mem_wr_o),
    .mem_ack_i          (mem_ack_i)
  );

  wb_dcache_datapath u_datapath (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .ctrl               (ctrl_if),
    .lsu_addr_i         (lsu_addr_i),
    .lsu_wdata_i        (lsu_wdata_i),
    .lsu_sel_byte_i     (lsu_sel_byte_i),
    .lsu_rdata_o        (lsu_rdata_o),
    .mem_rdata_i        (mem_rdata_i),
    .mem_wdata_o        (mem_wdata_o),
    .mem_addr_o         (mem_addr_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_wb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module tb_wb_dcache;

  // Window of 64 lines, so four lines share each cache index
  localparam logic [31:0] BASE = 32'h0004_2000;
  localparam int N_REQ = 400;
  // A miss with write-back stays well under 30 cycles and a flushed line under 12
  localparam int TIMEOUT_CYC = (N_REQ + 8) * 30 + `DCACHE_LINES * 12 + 20 + 10;

  logic          clk_i = 1'b0;
  logic          arst_n_i;
  logic          dmem_sel_i;
  logic          dcache_flush_i;
  logic          lsu_req_i;
  logic          lsu_wr_i;
  logic [31:0]   lsu_addr_i;
  logic [31:0]   lsu_wdata_i;
  logic [3:0]    lsu_sel_byte_i;
  logic          lsu_ack_o;
  logic [31:0]   lsu_rdata_o;
  logic          dcache_flush_ack_o;
  logic          mem_req_o;
  logic          mem_wr_o;
  logic [31:0]   mem_addr_o;
  logic [127:0]  mem_wdata_o;
  logic [127:0]  mem_rdata_i;
  logic          mem_ack_i;

  integer        seed;
  int unsigned   cycle_cnt = 0;

  // Reference word model, memory image and residency tracking
  logic [31:0]   ref_words [256];
  logic [127:0]  mem_lines [64];
  logic          touched [64];
  logic          line_valid [16];
  logic [27:0]   line_tag [16];

  wb_dcache_top DUT (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYC) begin
      $display("Timeout: the cache stopped answering before the tests finished");
      $display("RESULT: FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic compare_values(input string name, input logic [127:0] exp,
                                input logic [127:0] act);
    if (exp !== act) begin
      $display("Fail %s expected 0x%0h actual 0x%0h", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch in %s", name);
    end
  endtask

  // Initial memory contents depend on every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    fill_word = {addr[15:0], addr[31:16]} ^ (addr * 32'h0001_0193) ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0] sel);
    merge_bytes = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        merge_bytes[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
  endfunction

  // One LSU access that may first be held with the memory select low
  task automatic do_request(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] sel, input int sel_low_cycles);
    int unsigned widx;
    int unsigned lat;
    logic [3:0]  idx;
    logic        resident;
    widx     = (addr - BASE) >> 2;
    idx      = addr[7:4];
    resident = line_valid[idx] && (line_tag[idx] == addr[31:4]);
    @(posedge clk_i);
    lsu_req_i      <= 1'b1;
    lsu_wr_i       <= wr;
    lsu_addr_i     <= addr;
    lsu_wdata_i    <= wdata;
    lsu_sel_byte_i <= sel;
    if (sel_low_cycles > 0) begin
      dmem_sel_i <= 1'b0;
      repeat (sel_low_cycles) begin
        @(negedge clk_i);
        compare_values("sel_low_ack", 0, lsu_ack_o);
        compare_values("sel_low_mem_req", 0, mem_req_o);
      end
      @(posedge clk_i);
      dmem_sel_i <= 1'b1;
    end
    lat = 0;
    do begin
      @(negedge clk_i);
      lat++;
    end while (!lsu_ack_o);
    if (resident) begin
      compare_values("hit_latency", 2, lat);
    end
    if (wr) begin
      ref_words[widx] = merge_bytes(ref_words[widx], wdata, sel);
    end else begin
      compare_values("read_data", ref_words[widx], lsu_rdata_o);
    end
    // Only completed accesses may be written back later
    touched[widx >> 2] = 1'b1;
    line_valid[idx] = 1'b1;
    line_tag[idx]   = addr[31:4];
    @(posedge clk_i);
    lsu_req_i <= 1'b0;
  endtask

  // Line-wide memory that acks after 1 to 4 cycles
  initial begin : mem_responder
    int unsigned line_no;
    int unsigned delay;
    logic [31:0] offs;
    mem_ack_i   <= 1'b0;
    mem_rdata_i <= '0;
    forever begin
      @(negedge clk_i);
      if (mem_req_o) begin
        offs = mem_addr_o - BASE;
        compare_values("mem_addr_window", 1, offs < 32'h400);
        compare_values("mem_addr_align", 0, offs[3:0]);
        line_no = offs >> 4;
        delay   = 1 + ($unsigned($random(seed)) % 4);
        if (mem_wr_o) begin
          compare_values("wb_addr_touched", 1, touched[line_no]);
          mem_lines[line_no] = mem_wdata_o;
        end
        repeat (delay) @(posedge clk_i);
        mem_ack_i   <= 1'b1;
        mem_rdata_i <= mem_lines[line_no];
        @(posedge clk_i);
        mem_ack_i <= 1'b0;
      end
    end
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  sel;
    logic        wr;
    seed = 32'ha4e4_80f5;
    arst_n_i       <= 1'b0;
    dmem_sel_i     <= 1'b1;
    dcache_flush_i <= 1'b0;
    lsu_req_i      <= 1'b0;
    lsu_wr_i       <= 1'b0;
    lsu_addr_i     <= '0;
    lsu_wdata_i    <= '0;
    lsu_sel_byte_i <= '0;
    for (int w = 0; w < 256; w++) begin
      ref_words[w] = fill_word(BASE + 32'(w) * 4);
      mem_lines[w / 4][(w % 4) * 32 +: 32] = fill_word(BASE + 32'(w) * 4);
    end
    for (int l = 0; l < 64; l++) begin
      touched[l] = 1'b0;
    end
    for (int i = 0; i < 16; i++) begin
      line_valid[i] = 1'b0;
      line_tag[i]   = '0;
    end
    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Dirty line evicted by a conflicting tag, then read back
    do_request(1'b1, BASE + 32'h010, 32'hdead_beef, 4'b0101, 0);
    do_request(1'b0, BASE + 32'h110, 32'h0, 4'h0, 0);
    do_request(1'b0, BASE + 32'h010, 32'h0, 4'h0, 0);
    do_request(1'b0, BASE + 32'h204, 32'h0, 4'h0, 20);

    for (int n = 0; n < N_REQ / 2; n++) begin
      addr  = BASE + (32'($random(seed)) & 32'h0000_03fc);
      wr    = 1'($random(seed));
      wdata = $random(seed);
      sel   = 4'($random(seed));
      do_request(wr, addr, wdata, sel, 0);
      if (wr) begin
        do_request(1'b0, addr, 32'h0, 4'h0, 0);
      end
    end

    @(posedge clk_i);
    dcache_flush_i <= 1'b1;
    @(posedge clk_i);
    dcache_flush_i <= 1'b0;
    do begin
      @(negedge clk_i);
    end while (!dcache_flush_ack_o);
    for (int l = 0; l < 64; l++) begin
      if (touched[l]) begin
        compare_values("flush_line", {ref_words[4*l+3], ref_words[4*l+2],
                                      ref_words[4*l+1], ref_words[4*l]}, mem_lines[l]);
      end
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/dcache_pkg.sv
common/dcache_ctrl_if.sv
dcache/wb_dcache_controller.sv
dcache/wb_dcache_datapath.sv
hdl/wb_dcache_top.sv
tb/tb_wb_dcache.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_wb_dcache
FLIST      := flist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
